//--- rtl/gb_bus_pkg.sv
package gb_bus_pkg;

  // CPU side bus operation
  typedef enum logic [1:0] {
    BUS_IDLE  = 2'd0,
    BUS_READ  = 2'd1,
    BUS_WRITE = 2'd2
  } bus_op_t;

  // Decoded register identifier
  typedef enum logic [2:0] {
    REG_NONE = 3'd0,
    REG_DIV  = 3'd1,
    REG_TIMA = 3'd2,
    REG_TMA  = 3'd3,
    REG_TAC  = 3'd4,
    REG_IF   = 3'd5,
    REG_IE   = 3'd6
  } io_reg_t;

  // Raw request from the CPU, 26 bits
  typedef struct packed {
    bus_op_t     op;
    logic [15:0] addr;
    logic [7:0]  wdata;
  } bus_req_t;

  // Address-free access seen by register blocks, 12 bits
  typedef struct packed {
    io_reg_t    reg_id;
    logic       write;
    logic [7:0] wdata;
  } io_access_t;

endpackage

//--- rtl/gb_timer.sv
`timescale 1ns/1ns
`include "gb_timer_config.svh"

module gb_timer
  import gb_bus_pkg::*;
  import gb_timing_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  t_phase_t   t_phase,
  input  io_access_t access,
  output logic [7:0] timer_rdata,
  output logic       timer_req
);

  // Internal divider, DIV is the upper byte
  logic [15:0] div_cnt;
  logic [7:0]  tima;
  logic [7:0]  tma;
  logic [7:0]  tac;

  // Overflow seen, reload waits for T1
  logic tima_pending;

  logic sel_bit;
  logic sel_bit_prev;
  logic tick;

  logic wr_div;
  logic wr_tima;
  logic wr_tma;
  logic wr_tac;

  assign wr_div  = access.write && (access.reg_id == REG_DIV);
  assign wr_tima = access.write && (access.reg_id == REG_TIMA);
  assign wr_tma  = access.write && (access.reg_id == REG_TMA);
  assign wr_tac  = access.write && (access.reg_id == REG_TAC);

  // ========================================
  // Tick detection
  // ========================================
  // Rate select, enable gated before the edge detector
  always_comb begin
    unique case (tac[1:0])
      2'b00: sel_bit = div_cnt[9] & tac[2];
      2'b01: sel_bit = div_cnt[3] & tac[2];
      2'b10: sel_bit = div_cnt[5] & tac[2];
      2'b11: sel_bit = div_cnt[7] & tac[2];
    endcase
  end

  // Falling edge of gated bit
  assign tick = sel_bit_prev & ~sel_bit;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      div_cnt      <= 16'h0000;
      sel_bit_prev <= 1'b0;
    end else begin
      // Count every T-cycle unless restarted by a DIV write
      if (wr_div) begin
        div_cnt <= `GB_DIV_WRITE_VALUE;
      end else begin
        div_cnt <= div_cnt + 16'd1;
      end
      sel_bit_prev <= sel_bit;
    end
  end

  // ========================================
  // TIMA, overflow and reload
  // ========================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tima         <= 8'h00;
      tima_pending <= 1'b0;
      timer_req    <= 1'b0;
    end else begin
      // Request is a one-cycle pulse
      timer_req <= 1'b0;
      if (tima_pending && (t_phase == T1)) begin
        // Delayed reload at machine-cycle boundary
        tima         <= tma;
        tima_pending <= 1'b0;
        timer_req    <= 1'b1;
      end else if (wr_tima) begin
        tima <= access.wdata;
      end else if (tick) begin
        if (tima == 8'hFF) begin
          // Wrap to zero until the reload lands
          tima         <= 8'h00;
          tima_pending <= 1'b1;
        end else begin
          tima <= tima + 8'h01;
        end
      end
    end
  end

  // ========================================
  // TMA and TAC
  // ========================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tma <= 8'h00;
      tac <= `GB_TAC_FIXED_ONES;
    end else begin
      if (wr_tma) begin
        tma <= access.wdata;
      end
      // Upper TAC bits stay set
      if (wr_tac) begin
        tac <= access.wdata | `GB_TAC_FIXED_ONES;
      end
    end
  end

  // Register named by the access, 0xFF when not ours
  always_comb begin
    case (access.reg_id)
      REG_DIV:  timer_rdata = div_cnt[15:8];
      REG_TIMA: timer_rdata = tima;
      REG_TMA:  timer_rdata = tma;
      REG_TAC:  timer_rdata = tac;
      default:  timer_rdata = 8'hFF;
    endcase
  end

endmodule

//--- rtl/gb_timer_config.svh
`ifndef GB_TIMER_CONFIG_SVH
`define GB_TIMER_CONFIG_SVH

// ========================================
// Register addresses
// ========================================
`define GB_ADDR_DIV  16'hFF04
`define GB_ADDR_TIMA 16'hFF05
`define GB_ADDR_TMA  16'hFF06
`define GB_ADDR_TAC  16'hFF07
`define GB_ADDR_IF   16'hFF0F
`define GB_ADDR_IE   16'hFFFF

// ========================================
// Fixed bits and load values
// ========================================
// TAC bits 7:3 not implemented, read as one
`define GB_TAC_FIXED_ONES 8'hF8
// IF bits 7:5 not implemented, read as one
`define GB_IF_FIXED_ONES 8'hE0
// Divider restart value on any DIV write
`define GB_DIV_WRITE_VALUE 16'd4

`endif

//--- rtl/gb_timing_pkg.sv
package gb_timing_pkg;

  // Four T-cycles per machine cycle
  typedef enum logic [1:0] {
    T1 = 2'd0,
    T2 = 2'd1,
    T3 = 2'd2,
    T4 = 2'd3
  } t_phase_t;

endpackage

//--- rtl/interrupt_flags.sv
`timescale 1ns/1ns
`include "gb_timer_config.svh"

module interrupt_flags
  import gb_bus_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  io_access_t access,
  input  logic       timer_req,
  input  logic [4:0] int_req_ext,
  output logic [7:0] intr_rdata,
  output logic       irq
);

  // Only five sources exist, upper IF bits are fixed
  logic [4:0] if_flags;
  logic [7:0] ie_reg;
  logic [4:0] set_req;

  logic wr_if;
  logic wr_ie;

  assign wr_if = access.write && (access.reg_id == REG_IF);
  assign wr_ie = access.write && (access.reg_id == REG_IE);

  // Timer owns bit 2, external bit 2 dropped
  assign set_req = {int_req_ext[4:3], timer_req, int_req_ext[1:0]};

  // ========================================
  // Flag and enable registers
  // ========================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      if_flags <= 5'b00000;
      ie_reg   <= 8'h00;
      irq      <= 1'b0;
    end else begin
      // Set requests win over a CPU clear in the same cycle
      if (wr_if) begin
        if_flags <= access.wdata[4:0] | set_req;
      end else begin
        if_flags <= if_flags | set_req;
      end
      if (wr_ie) begin
        ie_reg <= access.wdata;
      end
      // Level line, one cycle behind IF and IE
      irq <= |(if_flags & ie_reg[4:0]);
    end
  end

  // Read side
  always_comb begin
    case (access.reg_id)
      REG_IF:  intr_rdata = `GB_IF_FIXED_ONES | {3'b000, if_flags};
      REG_IE:  intr_rdata = ie_reg;
      default: intr_rdata = 8'hFF;
    endcase
  end

endmodule

//--- rtl/io_bus_decode.sv
`timescale 1ns/1ns
`include "gb_timer_config.svh"

module io_bus_decode
  import gb_bus_pkg::*;
(
  input  bus_req_t   bus_req,
  input  logic [7:0] timer_rdata,
  input  logic [7:0] intr_rdata,
  output io_access_t access,
  output logic [7:0] rdata
);

  logic    bus_active;
  io_reg_t addr_reg;

  // Only real reads and writes reach the register blocks
  assign bus_active = (bus_req.op == BUS_READ) || (bus_req.op == BUS_WRITE);

  // ========================================
  // Address decode
  // ========================================
  always_comb begin
    case (bus_req.addr)
      `GB_ADDR_DIV:  addr_reg = REG_DIV;
      `GB_ADDR_TIMA: addr_reg = REG_TIMA;
      `GB_ADDR_TMA:  addr_reg = REG_TMA;
      `GB_ADDR_TAC:  addr_reg = REG_TAC;
      `GB_ADDR_IF:   addr_reg = REG_IF;
      `GB_ADDR_IE:   addr_reg = REG_IE;
      // Anything else is outside this block
      default:       addr_reg = REG_NONE;
    endcase
  end

  assign access.reg_id = bus_active ? addr_reg : REG_NONE;
  assign access.write  = (bus_req.op == BUS_WRITE);
  assign access.wdata  = bus_req.wdata;

  // ========================================
  // Read data select
  // ========================================
  // Open bus reads as 0xFF
  always_comb begin
    rdata = 8'hFF;
    if (bus_req.op == BUS_READ) begin
      case (access.reg_id)
        REG_DIV,
        REG_TIMA,
        REG_TMA,
        REG_TAC: rdata = timer_rdata;
        REG_IF,
        REG_IE:  rdata = intr_rdata;
        default: rdata = 8'hFF;
      endcase
    end
  end

endmodule

//--- rtl/t_phase_gen.sv
`timescale 1ns/1ns

module t_phase_gen
  import gb_timing_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  output t_phase_t t_phase
);

  t_phase_t phase_next;

  // Step to the following phase, T4 wraps to T1
  always_comb begin
    unique case (t_phase)
      T1:      phase_next = T2;
      T2:      phase_next = T3;
      T3:      phase_next = T4;
      default: phase_next = T1;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      t_phase <= T1;
    end else begin
      t_phase <= phase_next;
    end
  end

endmodule

//--- rtl/timer_subsystem.sv
`timescale 1ns/1ns

module timer_subsystem
  import gb_bus_pkg::*;
  import gb_timing_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  bus_req_t   bus_req,
  input  logic [4:0] int_req_ext,
  output logic [7:0] rdata,
  output logic       irq
);

  t_phase_t   t_phase;
  io_access_t access;
  logic [7:0] timer_rdata;
  logic [7:0] intr_rdata;
  logic       timer_req;

  // Machine-cycle phase
  t_phase_gen u_t_phase_gen (
    .clk     (clk),
    .reset   (reset),
    .t_phase (t_phase)
  );

  // Address decode and read mux
  io_bus_decode u_io_bus_decode (
    .bus_req     (bus_req),
    .timer_rdata (timer_rdata),
    .intr_rdata  (intr_rdata),
    .access      (access),
    .rdata       (rdata)
  );

  // DIV, TIMA, TMA, TAC
  gb_timer u_gb_timer (
    .clk         (clk),
    .reset       (reset),
    .t_phase     (t_phase),
    .access      (access),
    .timer_rdata (timer_rdata),
    .timer_req   (timer_req)
  );

  // IF, IE and CPU interrupt line
  interrupt_flags u_interrupt_flags (
    .clk         (clk),
    .reset       (reset),
    .access      (access),
    .timer_req   (timer_req),
    .int_req_ext (int_req_ext),
    .intr_rdata  (intr_rdata),
    .irq         (irq)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the timer subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f timer_subsystem.f --top-module timer_subsystem_tb -o timer_subsystem_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/timer_subsystem_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi
exit 0

//--- timer_subsystem.f
+incdir+rtl
rtl/gb_bus_pkg.sv
rtl/gb_timing_pkg.sv
rtl/t_phase_gen.sv
rtl/io_bus_decode.sv
rtl/gb_timer.sv
rtl/interrupt_flags.sv
rtl/timer_subsystem.sv
verification/timer_subsystem_checker.sv
verification/timer_subsystem_tb.sv

//--- verification/timer_subsystem_checker.sv
`timescale 1ns/1ns
`include "gb_timer_config.svh"

module timer_subsystem_checker
  import gb_bus_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input bus_req_t   bus_req,
  input io_access_t access,
  input logic [7:0] rdata,
  input logic       irq
);

  logic tac_read;
  // Failed property count
  int   fail_count = 0;

  // CPU read aimed at TAC
  assign tac_read = (bus_req.op == BUS_READ) && (access.reg_id == REG_TAC);

  // Interrupt line held low by reset
  irq_low_in_reset: assert property (@(posedge clk) reset |-> !irq)
    else begin
      $error("irq is high while reset is asserted");
      fail_count++;
    end

  // Open bus value on idle and write cycles
  rdata_open_bus: assert property (@(posedge clk) (bus_req.op != BUS_READ) |-> (rdata == 8'hFF))
    else begin
      $error("rdata is not 0xFF outside a read");
      fail_count++;
    end

  // Unimplemented TAC bits
  tac_fixed_ones: assert property (@(posedge clk) disable iff (reset)
      tac_read |-> ((rdata & `GB_TAC_FIXED_ONES) == `GB_TAC_FIXED_ONES))
    else begin
      $error("TAC read with upper bits clear");
      fail_count++;
    end

endmodule

bind timer_subsystem timer_subsystem_checker checker_i (
  .clk     (clk),
  .reset   (reset),
  .bus_req (bus_req),
  .access  (access),
  .rdata   (rdata),
  .irq     (irq)
);

//--- verification/timer_subsystem_tb.sv
`timescale 1ns/1ns
`include "gb_timer_config.svh"

module timer_subsystem_tb
  import gb_bus_pkg::*;
();

  logic       clk = 1'b0;
  logic       reset;
  bus_req_t   bus_req;
  logic [4:0] int_req_ext;
  logic [7:0] rdata;
  logic       irq;

  // Operations parsed from the test file
  logic [7:0] op_q[$];
  int         arg_a_q[$];
  int         arg_b_q[$];

  int errors = 0;
  int checks = 0;
  int limit_cycles = 0;
  int cycle_cnt = 0;
  // Divider model restarted on DIV writes
  int div_write_cycle = 0;
  bit div_known = 1'b0;

  timer_subsystem dut_i (
    .clk         (clk),
    .reset       (reset),
    .bus_req     (bus_req),
    .int_req_ext (int_req_ext),
    .rdata       (rdata),
    .irq         (irq)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ========================================
  // Test file loading
  // ========================================
  task automatic load_tests();
    int         fd;
    int         lines;
    int         idle_sum;
    int         v1;
    int         v2;
    logic [7:0] op;
    string      line;
    fd = $fopen("verification/timer_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file verification/timer_tests.txt");
      errors++;
      return;
    end
    lines = 0;
    idle_sum = 0;
    while (!$feof(fd)) begin
      line = "";
      v1 = 0;
      v2 = 0;
      void'($fgets(line, fd));
      lines++;
      // Skip blank and comment lines
      if ($sscanf(line, " %c", op) == 1 && op != "#") begin
        if (op == "N") begin
          void'($sscanf(line, " %c %d", op, v1));
          idle_sum += v1;
        end else begin
          void'($sscanf(line, " %c %h %h", op, v1, v2));
        end
        op_q.push_back(op);
        arg_a_q.push_back(v1);
        arg_b_q.push_back(v2);
      end
    end
    $fclose(fd);
    limit_cycles = lines * 20 + idle_sum;
  endtask

  // ========================================
  // Stimulus and checks
  // ========================================
  // Inputs change 1 ns after the edge and the bus idles by default
  task automatic next_cycle();
    @(posedge clk);
    #1;
    bus_req.op    = BUS_IDLE;
    bus_req.addr  = 16'h0000;
    bus_req.wdata = 8'h00;
  endtask

  task automatic check_byte(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    checks++;
    assert (actual == expected) else begin
      $display("ERROR %0t %s expected %02h actual %02h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic run_op(input logic [7:0] op, input int a, input int b);
    int          i;
    logic [15:0] div_model;
    case (op)
      "W": begin
        next_cycle();
        bus_req.op    = BUS_WRITE;
        bus_req.addr  = 16'(a);
        bus_req.wdata = 8'(b);
        if (16'(a) == `GB_ADDR_DIV) begin
          div_write_cycle = cycle_cnt;
          div_known = 1'b1;
        end
      end
      "R": begin
        next_cycle();
        bus_req.op   = BUS_READ;
        bus_req.addr = 16'(a);
        // Sample 1 ns before the next edge
        #2;
        check_byte("rdata", 8'(b), rdata);
        if (16'(a) == `GB_ADDR_DIV && div_known) begin
          div_model = 16'(`GB_DIV_WRITE_VALUE + (cycle_cnt - div_write_cycle - 1));
          check_byte("rdata (divider model)", div_model[15:8], rdata);
        end
      end
      "X": begin
        next_cycle();
        int_req_ext = 5'(a);
      end
      "I": begin
        next_cycle();
        #2;
        checks++;
        assert (irq == 1'(a)) else begin
          $display("ERROR %0t irq expected %0d actual %0d", $time, a[0], irq);
          errors++;
        end
      end
      "N": begin
        // Idle cycles also see open bus
        for (i = 0; i < a; i++) begin
          next_cycle();
          #2;
          check_byte("rdata", 8'hFF, rdata);
        end
      end
      default: begin
        $display("Unknown operation %c in the test file", op);
        errors++;
      end
    endcase
  endtask

  initial begin : main
    int i;
    reset       = 1'b1;
    bus_req     = '0;
    int_req_ext = 5'b00000;
    load_tests();
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    for (i = 0; i < op_q.size(); i++) begin
      run_op(op_q[i], arg_a_q[i], arg_b_q[i]);
    end
    @(posedge clk);
    errors += dut_i.checker_i.fail_count;
    if (checks == 0) begin
      $display("No checks were run");
      errors++;
    end
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Limit from file length and idle counts
  initial begin : watchdog
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout, tests did not complete within %0d cycles", limit_cycles);
    $display("Checks: %0d  Errors: %0d", checks, errors);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- verification/timer_tests.txt
# Columns: op arg1 arg2. W addr data, R addr expected, X ext_mask, I expected_irq
# N idle_cycles (decimal). All other values in hex.
# Reset values and register read back
R FF0F E0
R FF07 F8
W FF06 5A
R FF06 5A
W FF05 3C
R FF05 3C
W FF07 02
R FF07 FA
W FFFF 1F
R FFFF 1F
R FF00 FF
# Divider restart and count
W FF04 00
N 1100
R FF04 04
W FF04 77
N 300
R FF04 01
# Tick rates 16 64 256 1024, then enable clear
W FF07 05
W FF04 00
W FF05 00
N 36
R FF05 02
W FF07 06
W FF04 00
W FF05 00
N 156
R FF05 02
W FF07 07
W FF04 00
W FF05 00
N 636
R FF05 02
W FF07 04
W FF04 00
W FF05 00
N 1532
R FF05 01
W FF07 01
W FF04 00
W FF05 00
N 36
R FF05 00
# Overflow reload, timer interrupt, external request
W FFFF 04
W FF06 A5
W FF07 05
W FF04 00
W FF05 FE
N 38
R FF05 A5
R FF0F E4
I 1
W FF0F 00
N 1
I 0
X 05
X 00
I 0
R FF0F E1
